/* build.f */
source/bus_pkg.sv
source/bus_if.sv
source/addr_decoder.sv
source/scratch_bank.sv
source/resp_mux.sv
source/mem_bus_top.sv
verification/tb_clock_gen.sv
verification/mem_bus_tb.sv

/* verification/mem_bus_tb.sv */
// Testbench for the scratchpad memory bus top level.
// Runs a directed table, then seeded random back-to-back traffic, and checks
// every response one cycle after acceptance against a reference memory model.

`timescale 1ns/1ps
`default_nettype none

module mem_bus_tb import bus_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NR_RANDOM    = 200;
  localparam int RAND_SEED    = 55452;

  // one directed table row
  typedef struct {
    logic  req;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
  } entry_t;

  // response expected one cycle after acceptance
  typedef struct {
    logic  chk_rdata;
    data_t exp_rdata;
    logic  exp_err;
  } resp_t;

  logic  clk_sys;
  logic  rst_sys_n;
  logic  host_req;
  addr_t host_addr;
  logic  host_we;
  be_t   host_be;
  data_t host_wdata;
  logic  host_gnt;
  logic  host_rvalid;
  data_t host_rdata;
  logic  host_err;

  entry_t table_q [$];
  resp_t  pending_q [$];

  // reference memory, plus which words hold a fully written value
  data_t ref_mem [NR_BANKS][BANK_WORDS];
  logic  known [NR_BANKS][BANK_WORDS];

  int cycle_count = 0;
  int cycle_limit = 0;

  tb_clock_gen #(
    .CLK_PERIOD  (CLK_PERIOD),
    .RESET_CYCLES(RESET_CYCLES)
  ) u_clock_gen (
    .clk_sys_o (clk_sys),
    .rst_sys_no(rst_sys_n)
  );

  mem_bus_top uut (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .host_req_i   (host_req),
    .host_addr_i  (host_addr),
    .host_we_i    (host_we),
    .host_be_i    (host_be),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .host_err_o   (host_err)
  );

  task automatic check_data(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "flag mismatch");
    end
  endtask

  // window number from the map rule, -1 when unmapped
  function automatic int window_of(input addr_t addr);
    addr_t offset;
    offset = addr - MAP_START;
    // addresses below the map wrap to a huge offset
    if (offset >= NR_BANKS * MAP_STRIDE) return -1;
    if ((offset % MAP_STRIDE) >= BANK_SIZE) return -1;
    return int'(offset / MAP_STRIDE);
  endfunction

  function automatic int word_of(input addr_t addr);
    return int'((addr >> 2) % BANK_WORDS);
  endfunction

  // enabled bytes from new, the rest from old
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic add_entry(input logic req, input logic we, input addr_t addr, input be_t be,
                           input data_t wdata, input data_t exp_rdata, input logic exp_err);
    entry_t e;
    e.req       = req;
    e.we        = we;
    e.addr      = addr;
    e.be        = be;
    e.wdata     = wdata;
    e.exp_rdata = exp_rdata;
    e.exp_err   = exp_err;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    // idle after reset
    add_entry(1'b0, 1'b0, 32'h0000_0000, 4'h0, 32'h0, 32'h0, 1'b0);
    add_entry(1'b0, 1'b0, 32'h0000_0000, 4'h0, 32'h0, 32'h0, 1'b0);
    // own value per bank, same offset
    add_entry(1'b1, 1'b1, 32'h8000_0010, 4'hF, 32'h1111_A0A0, 32'h0, 1'b0);
    add_entry(1'b1, 1'b1, 32'h8000_1010, 4'hF, 32'h2222_B1B1, 32'h0, 1'b0);
    add_entry(1'b1, 1'b1, 32'h8000_2010, 4'hF, 32'h3333_C2C2, 32'h0, 1'b0);
    add_entry(1'b1, 1'b1, 32'h8000_3010, 4'hF, 32'h4444_D3D3, 32'h0, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_0010, 4'h0, 32'h0, 32'h1111_A0A0, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_1010, 4'h0, 32'h0, 32'h2222_B1B1, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_2010, 4'h0, 32'h0, 32'h3333_C2C2, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_3010, 4'h0, 32'h0, 32'h4444_D3D3, 1'b0);
    // byte lanes 0 and 2 replaced
    add_entry(1'b1, 1'b1, 32'h8000_0024, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b0);
    add_entry(1'b1, 1'b1, 32'h8000_0024, 4'h5, 32'h1234_5678, 32'h0, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_0024, 4'h0, 32'h0, 32'hDE34_BE78, 1'b0);
    // top lane only, last word of bank 3
    add_entry(1'b1, 1'b1, 32'h8000_30FC, 4'hF, 32'h0BAD_F00D, 32'h0, 1'b0);
    add_entry(1'b1, 1'b1, 32'h8000_30FC, 4'h8, 32'hA5FF_FFFF, 32'h0, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_30FC, 4'h0, 32'h0, 32'hA5AD_F00D, 1'b0);
    // misses; the two writes alias word 4 of banks 0 and 1
    add_entry(1'b1, 1'b1, 32'h8000_0110, 4'hF, 32'hFFFF_FFFF, 32'h0, 1'b1);
    add_entry(1'b1, 1'b1, 32'h9000_1010, 4'hF, 32'hFFFF_FFFF, 32'h0, 1'b1);
    add_entry(1'b1, 1'b0, 32'h8000_4010, 4'h0, 32'h0, 32'h0, 1'b1);
    add_entry(1'b1, 1'b0, 32'h0000_0010, 4'h0, 32'h0, 32'h0, 1'b1);
    add_entry(1'b0, 1'b0, 32'h0000_0000, 4'h0, 32'h0, 32'h0, 1'b0);
    // aliased words untouched
    add_entry(1'b1, 1'b0, 32'h8000_0010, 4'h0, 32'h0, 32'h1111_A0A0, 1'b0);
    add_entry(1'b1, 1'b0, 32'h8000_1010, 4'h0, 32'h0, 32'h2222_B1B1, 1'b0);
  endtask

  // response to last cycle's request, or silence
  task automatic check_response();
    resp_t r;
    if (pending_q.size() > 0) begin
      r = pending_q.pop_front();
      check_flag("host_rvalid_o", host_rvalid, 1'b1);
      check_flag("host_err_o", host_err, r.exp_err);
      if (r.chk_rdata) check_data("host_rdata_o", host_rdata, r.exp_rdata);
    end else begin
      check_flag("host_rvalid_o", host_rvalid, 1'b0);
      check_flag("host_err_o", host_err, 1'b0);
    end
  endtask

  // one bus cycle, driven on the falling edge
  task automatic apply_txn(input logic req, input logic we, input addr_t addr, input be_t be,
                           input data_t wdata, input data_t exp_rdata, input logic exp_err,
                           input logic chk_rdata);
    resp_t r;
    int    win;
    int    word;
    @(negedge clk_sys);
    check_response();
    host_req   = req;
    host_we    = we;
    host_addr  = addr;
    host_be    = be;
    host_wdata = wdata;
    win        = window_of(addr);
    word       = word_of(addr);
    if (req) begin
      r.chk_rdata = chk_rdata;
      r.exp_rdata = exp_rdata;
      r.exp_err   = exp_err;
      pending_q.push_back(r);
      if (we && win >= 0) begin
        ref_mem[win][word] = merge_bytes(ref_mem[win][word], wdata, be);
        if (be == '1) known[win][word] = 1'b1;
      end
    end
    // grant is combinational
    #1;
    check_flag("host_gnt_o", host_gnt, req);
  endtask

  task automatic run_random_txn();
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
    int    bank;
    int    word;
    int    win;
    wdata = $urandom;
    we    = $urandom % 2;
    be    = be_t'($urandom);
    if ($urandom % 8 == 0) begin
      bank = int'($urandom % NR_BANKS);
      // below the map, or just past the end of a window
      if ($urandom % 2 == 0) addr = addr_t'($urandom) & 32'h7FFF_FFFC;
      else addr = BANK_BASE[bank] + addr_t'(BANK_SIZE) + addr_t'(($urandom % BANK_WORDS) * 4);
    end else begin
      bank = int'($urandom % NR_BANKS);
      word = int'($urandom % BANK_WORDS);
      addr = MAP_START + addr_t'(bank) * MAP_STRIDE + addr_t'(word * 4);
      // never read a word the model does not know
      if (!known[bank][word]) begin
        we = 1'b1;
        be = '1;
      end
    end
    win = window_of(addr);
    if (win < 0) apply_txn(1'b1, we, addr, be, wdata, '0, 1'b1, 1'b1);
    else apply_txn(1'b1, we, addr, be, wdata, ref_mem[win][word_of(addr)], 1'b0, !we);
  endtask

  // run limit
  always @(posedge clk_sys) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: test did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_be    = '0;
    host_wdata = '0;
    void'($urandom(RAND_SEED));
    for (int k = 0; k < NR_BANKS; k++) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        ref_mem[k][w] = '0;
        known[k][w]   = 1'b0;
      end
    end
    build_table();
    cycle_limit = (table_q.size() + NR_RANDOM + RESET_CYCLES) * 2;
    @(posedge rst_sys_n);
    // directed rows
    foreach (table_q[i]) begin
      apply_txn(table_q[i].req, table_q[i].we, table_q[i].addr, table_q[i].be,
                table_q[i].wdata, table_q[i].exp_rdata, table_q[i].exp_err,
                !table_q[i].we || table_q[i].exp_err);
    end
    // random traffic, one request per cycle
    for (int i = 0; i < NR_RANDOM; i++) begin
      run_random_txn();
    end
    // drain the last response, then one quiet cycle
    apply_txn(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
    apply_txn(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Clock and reset source for the memory bus testbench.
// Free-running clock, active-low reset held for RESET_CYCLES rising edges.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int CLK_PERIOD   = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_sys_o,
  output logic rst_sys_no
);

  // 50 percent duty clock
  initial begin
    clk_sys_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys_o = ~clk_sys_o;
  end

  // release away from the rising edge
  initial begin
    rst_sys_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_sys_o);
    @(negedge clk_sys_o);
    rst_sys_no = 1'b1;
  end

endmodule

`default_nettype wire

/* source/mem_bus_top.sv */
// Top level of the scratchpad memory bus.
// One host port with an immediate grant and a response one cycle later.
// The decoder fans requests out to NR_BANKS scratchpad banks over bus_if
// ports, and the response mux brings the answer back to the host.

`timescale 1ns/1ps
`default_nettype none

module mem_bus_top import bus_pkg::*; (
  input  logic  clk_sys_i,
  input  logic  rst_sys_ni,

  // host request
  input  logic  host_req_i,
  input  addr_t host_addr_i,
  input  logic  host_we_i,
  input  be_t   host_be_i,
  input  data_t host_wdata_i,
  output logic  host_gnt_o,

  // host response
  output logic  host_rvalid_o,
  output data_t host_rdata_o,
  output logic  host_err_o
);

  // decoder to response mux
  logic      acc_valid;
  bank_idx_t acc_bank;
  logic      acc_miss;

  // one device port per bank
  bus_if bank_if [NR_BANKS] ();

  // address decode and request steering
  addr_decoder u_decoder (
    .host_req_i  (host_req_i),
    .host_addr_i (host_addr_i),
    .host_we_i   (host_we_i),
    .host_be_i   (host_be_i),
    .host_wdata_i(host_wdata_i),
    .host_gnt_o  (host_gnt_o),

    .bank_o      (bank_if),

    .acc_valid_o (acc_valid),
    .acc_bank_o  (acc_bank),
    .acc_miss_o  (acc_miss)
  );

  // scratchpad banks
  // all identical, each sits at its own BANK_BASE entry
  for (genvar k = 0; k < NR_BANKS; k++) begin : g_bank
    scratch_bank u_bank (
      .clk_sys_i (clk_sys_i),
      .rst_sys_ni(rst_sys_ni),
      .port_i    (bank_if[k])
    );
  end

  // response selection and error path
  resp_mux u_resp_mux (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),

    .acc_valid_i  (acc_valid),
    .acc_bank_i   (acc_bank),
    .acc_miss_i   (acc_miss),

    .bank_i       (bank_if),

    .host_rvalid_o(host_rvalid_o),
    .host_rdata_o (host_rdata_o),
    .host_err_o   (host_err_o)
  );

endmodule

`default_nettype wire

/* source/resp_mux.sv */
// Response path of the memory bus.
// Remembers where each accepted request went and, one cycle later, returns
// that bank's rvalid and rdata to the host. A request that hit no window
// is answered here with err high and zero data.

`timescale 1ns/1ps
`default_nettype none

module resp_mux import bus_pkg::*; (
  input  logic      clk_sys_i,
  input  logic      rst_sys_ni,

  // target report from the decoder
  input  logic      acc_valid_i,
  input  bank_idx_t acc_bank_i,
  input  logic      acc_miss_i,

  // bank responses
  bus_if.resp_mp    bank_i [NR_BANKS],

  // host response
  output logic      host_rvalid_o,
  output data_t     host_rdata_o,
  output logic      host_err_o
);

  // target of last cycle's request
  bank_idx_t sel_q;
  // last cycle's request missed every window
  logic      miss_valid_q;

  // bank responses pulled out of the interface array
  logic [NR_BANKS-1:0] bank_rvalid;
  data_t               bank_rdata [NR_BANKS];

  for (genvar k = 0; k < NR_BANKS; k++) begin : g_gather
    assign bank_rvalid[k] = bank_i[k].rvalid;
    assign bank_rdata[k]  = bank_i[k].rdata;
  end

  // target tracking
  // sel_q keeps its value between requests
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sel_q        <= '0;
      miss_valid_q <= 1'b0;
    end else begin
      miss_valid_q <= acc_valid_i & acc_miss_i;
      if (acc_valid_i) begin
        sel_q <= acc_bank_i;
      end
    end
  end

  // on a miss no bank saw req, so the selected bank's rvalid is low
  assign host_rvalid_o = miss_valid_q | bank_rvalid[sel_q];

  // zero data alongside the error
  assign host_rdata_o = miss_valid_q ? '0 : bank_rdata[sel_q];

  assign host_err_o = miss_valid_q;

endmodule

`default_nettype wire

/* source/scratch_bank.sv */
// One scratchpad word bank hanging off the memory bus.
// Holds BANK_WORDS words; writes honor the byte enables and land at the same
// edge the request is taken. Every request, read or write, gets rvalid one
// cycle later, and a read brings the addressed word along as rdata.

`timescale 1ns/1ps
`default_nettype none

module scratch_bank import bus_pkg::*; (
  input  logic   clk_sys_i,
  input  logic   rst_sys_ni,

  // request in, response out
  bus_if.bank_mp port_i
);

  // storage array
  data_t mem_q [BANK_WORDS];

  // response registers
  logic  rvalid_q;
  data_t rdata_q;

  // decoded request kinds
  logic  wr_en;
  logic  rd_en;

  assign wr_en = port_i.req & port_i.we;
  assign rd_en = port_i.req & ~port_i.we;

  // byte-merged write
  // disabled lanes keep their old contents
  always_ff @(posedge clk_sys_i) begin
    if (wr_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (port_i.be[b]) begin
          mem_q[port_i.addr][b*BYTE_W +: BYTE_W] <= port_i.wdata[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // read data register
  // only loaded on a read, holds its value across writes
  always_ff @(posedge clk_sys_i) begin
    if (rd_en) begin
      rdata_q <= mem_q[port_i.addr];
    end
  end

  // one response per request, read or write
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= port_i.req;
    end
  end

  // response back onto the bus port
  assign port_i.rvalid = rvalid_q;
  assign port_i.rdata  = rdata_q;

endmodule

`default_nettype wire

/* source/addr_decoder.sv */
// Host-side address decoder of the memory bus.
// Matches the host address against the base/mask table, steers the request
// to the one matching bank and tells the response mux where it went.
// Purely combinational; every request is granted in the cycle it arrives.

`timescale 1ns/1ps
`default_nettype none

module addr_decoder import bus_pkg::*; (
  // host request side
  input  logic      host_req_i,
  input  addr_t     host_addr_i,
  input  logic      host_we_i,
  input  be_t       host_be_i,
  input  data_t     host_wdata_i,
  output logic      host_gnt_o,

  // one request port per bank
  bus_if.decoder_mp bank_o [NR_BANKS],

  // target report for the response path
  output logic      acc_valid_o,
  output bank_idx_t acc_bank_o,
  output logic      acc_miss_o
);

  // one hit bit per window
  logic [NR_BANKS-1:0] hit;

  // word index inside whichever bank is hit
  word_idx_t word_idx;

  assign word_idx = host_addr_i[WORD_MSB:WORD_LSB];

  // window compare against the shared mask
  always_comb begin
    for (int k = 0; k < NR_BANKS; k++) begin
      hit[k] = ((host_addr_i & BANK_MASK) == BANK_BASE[k]);
    end
  end

  // per-bank request steering
  for (genvar k = 0; k < NR_BANKS; k++) begin : g_steer
    // only the hit bank sees req
    assign bank_o[k].req   = host_req_i & hit[k];
    // payload goes to every bank, req qualifies it
    assign bank_o[k].addr  = word_idx;
    assign bank_o[k].we    = host_we_i;
    assign bank_o[k].be    = host_be_i;
    assign bank_o[k].wdata = host_wdata_i;
  end

  // immediate grant, no other host to wait for
  assign host_gnt_o = host_req_i;

  // accepted this cycle
  assign acc_valid_o = host_req_i;

  // no window matched, so no bank gets req
  assign acc_miss_o = ~|hit;

  // one-hot hit to bank index
  // windows do not overlap, so at most one bit is set
  always_comb begin
    acc_bank_o = '0;
    for (int k = 0; k < NR_BANKS; k++) begin
      if (hit[k]) begin
        acc_bank_o = bank_idx_t'(k);
      end
    end
  end

endmodule

`default_nettype wire

/* source/bus_if.sv */
// One device port of the memory bus, between the decoder and a scratchpad bank.
// The decoder drives the request side, the bank answers with rvalid and rdata
// one cycle later, and the response mux only watches the response side.

`timescale 1ns/1ps
`default_nettype none

interface bus_if import bus_pkg::*; ();

  // request, valid in the cycle it is granted
  logic      req;
  word_idx_t addr;
  logic      we;
  be_t       be;
  data_t     wdata;

  // response, one cycle after req
  logic      rvalid;
  data_t     rdata;

  // decoder side drives the request
  modport decoder_mp (
    output req, addr, we, be, wdata
  );

  // bank takes the request and answers
  modport bank_mp (
    input  req, addr, we, be, wdata,
    output rvalid, rdata
  );

  // response mux only listens
  modport resp_mp (
    input rvalid, rdata
  );

endinterface

`default_nettype wire

/* source/bus_pkg.sv */
// Shared widths, bus types and the address map of the scratchpad memory bus.
// Every RTL module and the testbench take these by a wildcard import.

`default_nettype none

package bus_pkg;

  // host bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;
  localparam int BE_W   = DATA_W / BYTE_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // bank population
  localparam int NR_BANKS   = 4;
  localparam int BANK_IDX_W = $clog2(NR_BANKS);

  typedef logic [BANK_IDX_W-1:0] bank_idx_t;

  // one bank is 64 words of 32 bits
  localparam int BANK_WORDS = 64;
  localparam int BANK_SIZE  = BANK_WORDS * BE_W;

  // word index is taken from address bits 7 down to 2
  localparam int WORD_LSB = $clog2(BE_W);
  localparam int WORD_W   = $clog2(BANK_WORDS);
  localparam int WORD_MSB = WORD_LSB + WORD_W - 1;

  typedef logic [WORD_W-1:0] word_idx_t;

  // address map
  // windows sit 4 KiB apart, but each one only spans BANK_SIZE bytes
  localparam addr_t MAP_START  = 32'h8000_0000;
  localparam addr_t MAP_STRIDE = 32'h0000_1000;

  localparam addr_t BANK_BASE [NR_BANKS] = '{
    MAP_START,
    MAP_START + MAP_STRIDE,
    MAP_START + 2 * MAP_STRIDE,
    MAP_START + 3 * MAP_STRIDE
  };

  // one mask for every window
  localparam addr_t BANK_MASK = ~(addr_t'(BANK_SIZE) - addr_t'(1));

endpackage

`default_nettype wire
